// File: src/grid_pkg.sv
package grid_pkg;

    // Playfield geometry, row 0 at the bottom
    localparam int GRID_COLS  = 10;
    localparam int GRID_ROWS  = 20;
    localparam int GRID_CELLS = GRID_COLS * GRID_ROWS;

    // Cell index is row * GRID_COLS + column
    typedef logic [7:0] cell_idx_t;

    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    // One bit per row, set for rows that are full
    typedef logic [GRID_ROWS-1:0] row_mask_t;

    // Marks a piece cell that falls below index 0
    localparam cell_idx_t CELL_NONE = 8'd255;

endpackage

// File: src/piece_pkg.sv
package piece_pkg;

    // The code doubles as the color of a placed cell
    typedef enum logic [2:0] {
        PIECE_NONE   = 3'd0,
        PIECE_SQUARE = 3'd1,
        PIECE_BAR    = 3'd2,
        PIECE_S      = 3'd3,
        PIECE_Z      = 3'd4,
        PIECE_L      = 3'd5,
        PIECE_J      = 3'd6,
        PIECE_T      = 3'd7
    } piece_type_t;

    typedef logic [1:0] rotation_t;

    // 0 is an empty cell
    typedef logic [2:0] color_t;

endpackage

// File: src/piece_cell_decoder.sv
module piece_cell_decoder (
    input  piece_pkg::piece_type_t piece_type,
    input  piece_pkg::rotation_t   rotation,
    input  grid_pkg::cell_idx_t    location,
    output grid_pkg::cell_idx_t    cell_0,
    output grid_pkg::cell_idx_t    cell_1,
    output grid_pkg::cell_idx_t    cell_2,
    output grid_pkg::cell_idx_t    cell_3
);

    // Offsets relative to the anchor, one per covered cell
    int   off [4];
    logic shape_ok;

    function automatic grid_pkg::cell_idx_t offset_cell(
        input grid_pkg::cell_idx_t loc,
        input int                  delta
    );
        int sum;
        sum = int'(loc) + delta;
        if (sum < 0 || sum > 255) begin
            return grid_pkg::CELL_NONE;
        end
        return grid_pkg::cell_idx_t'(sum);
    endfunction

    always_comb begin
        off      = '{0, 0, 0, 0};
        shape_ok = 1'b1;

        case (piece_type)
            piece_pkg::PIECE_SQUARE: begin
                off = '{0, 1, -10, -9};
            end
            piece_pkg::PIECE_BAR: begin
                // Odd rotations stand the bar upright
                if (rotation[0]) begin
                    off = '{10, 0, -10, -20};
                end else begin
                    off = '{0, -1, 1, 2};
                end
            end
            piece_pkg::PIECE_S: begin
                if (rotation[0]) begin
                    off = '{0, -10, -9, -19};
                end else begin
                    off = '{0, 1, -10, -11};
                end
            end
            piece_pkg::PIECE_Z: begin
                if (rotation[0]) begin
                    off = '{1, -9, -10, -20};
                end else begin
                    off = '{0, 1, -9, -8};
                end
            end
            piece_pkg::PIECE_L: begin
                case (rotation)
                    2'd0:    off = '{0, -10, -20, -19};
                    2'd1:    off = '{0, 1, 2, -10};
                    2'd2:    off = '{0, 1, -9, -19};
                    default: off = '{2, -8, -9, -10};
                endcase
            end
            piece_pkg::PIECE_J: begin
                case (rotation)
                    2'd0:    off = '{0, -10, -20, -21};
                    2'd1:    off = '{-1, -11, -10, -9};
                    2'd2:    off = '{0, -1, -11, -21};
                    default: off = '{-1, 0, 1, -9};
                endcase
            end
            piece_pkg::PIECE_T: begin
                case (rotation)
                    2'd0:    off = '{0, -1, 1, -10};
                    2'd1:    off = '{0, 10, -10, -1};
                    2'd2:    off = '{0, 10, 1, -1};
                    default: off = '{0, 10, -10, 1};
                endcase
            end
            default: begin
                shape_ok = 1'b0;
            end
        endcase

        if (shape_ok) begin
            cell_0 = offset_cell(location, off[0]);
            cell_1 = offset_cell(location, off[1]);
            cell_2 = offset_cell(location, off[2]);
            cell_3 = offset_cell(location, off[3]);
        end else begin
            cell_0 = grid_pkg::CELL_NONE;
            cell_1 = grid_pkg::CELL_NONE;
            cell_2 = grid_pkg::CELL_NONE;
            cell_3 = grid_pkg::CELL_NONE;
        end
    end

endmodule

// File: src/grid_update_fsm.sv
module grid_update_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   place,
    input  piece_pkg::piece_type_t piece_type,
    input  piece_pkg::rotation_t   rotation,
    input  grid_pkg::cell_idx_t    location,
    input  logic                   clear,
    input  grid_pkg::row_mask_t    full_rows,
    input  grid_pkg::cell_idx_t    cell_0,
    input  grid_pkg::cell_idx_t    cell_1,
    input  grid_pkg::cell_idx_t    cell_2,
    input  grid_pkg::cell_idx_t    cell_3,
    input  piece_pkg::color_t      scan_data,
    output piece_pkg::piece_type_t held_type,
    output piece_pkg::rotation_t   held_rotation,
    output grid_pkg::cell_idx_t    held_location,
    output logic                   busy,
    output logic                   wr_en,
    output grid_pkg::cell_idx_t    wr_addr,
    output piece_pkg::color_t      wr_data,
    output grid_pkg::cell_idx_t    scan_addr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_PIECE,
        ST_COMPACT,
        ST_FILL
    } grid_state_t;

    localparam grid_pkg::row_idx_t LAST_ROW = grid_pkg::row_idx_t'(grid_pkg::GRID_ROWS - 1);
    localparam grid_pkg::row_idx_t END_ROW  = grid_pkg::row_idx_t'(grid_pkg::GRID_ROWS);
    localparam grid_pkg::col_idx_t LAST_COL = grid_pkg::col_idx_t'(grid_pkg::GRID_COLS - 1);

    grid_state_t         state;
    logic [1:0]          piece_step;
    grid_pkg::row_idx_t  read_row;
    grid_pkg::row_idx_t  write_row;
    grid_pkg::col_idx_t  col;
    grid_pkg::row_mask_t held_rows;
    grid_pkg::cell_idx_t cur_cell;
    logic                row_masked;

    function automatic grid_pkg::cell_idx_t cell_at(
        input grid_pkg::row_idx_t row,
        input grid_pkg::col_idx_t column
    );
        return grid_pkg::cell_idx_t'(row * grid_pkg::GRID_COLS + column);
    endfunction

    // Command operands, captured when a command is accepted
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && place) begin
            held_type     <= piece_type;
            held_rotation <= rotation;
            held_location <= location;
        end else if (state == ST_IDLE && clear) begin
            held_rows <= full_rows;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            piece_step <= '0;
            read_row   <= '0;
            write_row  <= '0;
            col        <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (place) begin
                        state      <= ST_WRITE_PIECE;
                        piece_step <= '0;
                    end else if (clear) begin
                        state     <= ST_COMPACT;
                        read_row  <= '0;
                        write_row <= '0;
                        col       <= '0;
                    end
                end
                ST_WRITE_PIECE: begin
                    piece_step <= piece_step + 2'd1;
                    if (piece_step == 2'd3) begin
                        state <= ST_IDLE;
                    end
                end
                ST_COMPACT: begin
                    // A full row costs one cycle, a kept row one cycle per column
                    if (row_masked || col == LAST_COL) begin
                        col      <= '0;
                        read_row <= read_row + 5'd1;
                        if (!row_masked) begin
                            write_row <= write_row + 5'd1;
                        end
                        if (read_row == LAST_ROW) begin
                            state <= ST_FILL;
                        end
                    end else begin
                        col <= col + 4'd1;
                    end
                end
                ST_FILL: begin
                    if (write_row == END_ROW) begin
                        state <= ST_IDLE;
                    end else if (col == LAST_COL) begin
                        col       <= '0;
                        write_row <= write_row + 5'd1;
                    end else begin
                        col <= col + 4'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        case (piece_step)
            2'd0:    cur_cell = cell_0;
            2'd1:    cur_cell = cell_1;
            2'd2:    cur_cell = cell_2;
            default: cur_cell = cell_3;
        endcase
    end

    assign row_masked = held_rows[read_row];
    assign scan_addr  = cell_at(read_row, col);
    assign busy       = (state != ST_IDLE);

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = cell_at(write_row, col);
        wr_data = '0;
        case (state)
            ST_WRITE_PIECE: begin
                // Cells off the grid still take their cycle
                wr_en   = (cur_cell < grid_pkg::cell_idx_t'(grid_pkg::GRID_CELLS));
                wr_addr = cur_cell;
                wr_data = piece_pkg::color_t'(held_type);
            end
            ST_COMPACT: begin
                wr_en   = !row_masked;
                wr_data = scan_data;
            end
            ST_FILL: begin
                wr_en = (write_row != END_ROW);
            end
            default: ;
        endcase
    end

endmodule

// File: src/color_grid_ram.sv
module color_grid_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  grid_pkg::cell_idx_t wr_addr,
    input  piece_pkg::color_t   wr_data,
    input  grid_pkg::cell_idx_t read_addr,
    output piece_pkg::color_t   read_data,
    input  grid_pkg::cell_idx_t scan_addr,
    output piece_pkg::color_t   scan_data
);

    localparam grid_pkg::cell_idx_t CELL_END = grid_pkg::cell_idx_t'(grid_pkg::GRID_CELLS);

    piece_pkg::color_t              mem [grid_pkg::GRID_CELLS];
    logic [grid_pkg::GRID_CELLS-1:0] written;

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr < CELL_END) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // A cell never written since reset reads as empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
        end else if (wr_en && wr_addr < CELL_END) begin
            written[wr_addr] <= 1'b1;
        end
    end

    assign read_data = (read_addr < CELL_END && written[read_addr]) ? mem[read_addr] : '0;
    assign scan_data = (scan_addr < CELL_END && written[scan_addr]) ? mem[scan_addr] : '0;

endmodule

// File: src/tetris_color_grid.sv
module tetris_color_grid (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   place,
    input  piece_pkg::piece_type_t piece_type,
    input  piece_pkg::rotation_t   rotation,
    input  grid_pkg::cell_idx_t    location,
    input  logic                   clear,
    input  grid_pkg::row_mask_t    full_rows,
    output logic                   busy,
    input  grid_pkg::cell_idx_t    read_addr,
    output piece_pkg::color_t      read_data
);

    piece_pkg::piece_type_t held_type;
    piece_pkg::rotation_t   held_rotation;
    grid_pkg::cell_idx_t    held_location;
    grid_pkg::cell_idx_t    cell_0;
    grid_pkg::cell_idx_t    cell_1;
    grid_pkg::cell_idx_t    cell_2;
    grid_pkg::cell_idx_t    cell_3;
    logic                   wr_en;
    grid_pkg::cell_idx_t    wr_addr;
    piece_pkg::color_t      wr_data;
    grid_pkg::cell_idx_t    scan_addr;
    piece_pkg::color_t      scan_data;

    // Decoder works on the operands held by the FSM
    piece_cell_decoder decode_i (
        .piece_type (held_type),
        .rotation   (held_rotation),
        .location   (held_location),
        .cell_0     (cell_0),
        .cell_1     (cell_1),
        .cell_2     (cell_2),
        .cell_3     (cell_3)
    );

    grid_update_fsm execute_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .place         (place),
        .piece_type    (piece_type),
        .rotation      (rotation),
        .location      (location),
        .clear         (clear),
        .full_rows     (full_rows),
        .cell_0        (cell_0),
        .cell_1        (cell_1),
        .cell_2        (cell_2),
        .cell_3        (cell_3),
        .scan_data     (scan_data),
        .held_type     (held_type),
        .held_rotation (held_rotation),
        .held_location (held_location),
        .busy          (busy),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .scan_addr     (scan_addr)
    );

    color_grid_ram result_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .read_addr (read_addr),
        .read_data (read_data),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

endmodule

// File: verif/tetris_color_grid_assertions.sv
module tetris_color_grid_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                busy,
    input logic                wr_en,
    input grid_pkg::cell_idx_t wr_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;
    int busy_len;

    // Consecutive busy cycles seen so far
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_len <= 0;
        end else if (busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
        else begin
            fail_count++;
            $error("busy is high in the first cycle after reset");
        end

    write_only_busy: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> busy)
        else begin
            fail_count++;
            $error("wr_en asserted while the FSM is idle");
        end

    write_in_grid: assert property (@(posedge clk) disable iff (!rst_n)
                                    wr_en |-> wr_addr < grid_pkg::GRID_CELLS)
        else begin
            fail_count++;
            $error("wr_en with wr_addr 0x%h outside the grid", wr_addr);
        end

    // Full mask clear is the longest command at 221 cycles
    busy_bounded: assert property (@(posedge clk) disable iff (!rst_n) busy |-> busy_len < 221)
        else begin
            fail_count++;
            $error("busy held high for more than 221 cycles");
        end

endmodule

// File: verif/grid_checker.sv
module grid_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                place,
    input  logic                busy,
    input  logic                check_en,
    input  grid_pkg::cell_idx_t read_addr,
    input  piece_pkg::color_t   exp_color,
    input  piece_pkg::color_t   read_data,
    output int                  read_errors,
    output int                  busy_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    int   read_count = 0;
    int   busy_count = 0;
    logic tracking;
    int   busy_len;

    assign read_errors = read_count;
    assign busy_errors = busy_count;

    // Read port is combinational, so the value is settled at the rising edge
    always @(posedge clk) begin
        if (rst_n && check_en) begin
            if (read_data !== exp_color) begin
                $display("[FAIL] read_data addr=0x%h expected=0x%h actual=0x%h",
                         read_addr, exp_color, read_data);
                read_count++;
            end
        end
    end

    // An accepted place must hold busy for four cycles, one per cell
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tracking = 1'b0;
            busy_len = 0;
        end else begin
            if (tracking && !busy) begin
                tracking = 1'b0;
                if (busy_len != 4) begin
                    $display("busy stayed high for %0d cycles after a place instead of 4",
                             busy_len);
                    busy_count++;
                end
            end
            if (tracking) begin
                busy_len++;
            end else if (place && !busy) begin
                tracking = 1'b1;
                busy_len = 0;
            end
        end
    end

endmodule

// File: verif/tb_tetris_color_grid.sv
module tb_tetris_color_grid;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   rst_n;
    logic                   place;
    piece_pkg::piece_type_t piece_type;
    piece_pkg::rotation_t   rotation;
    grid_pkg::cell_idx_t    location;
    logic                   clear;
    grid_pkg::row_mask_t    full_rows;
    logic                   busy;
    grid_pkg::cell_idx_t    read_addr;
    piece_pkg::color_t      read_data;
    logic                   check_en;
    piece_pkg::color_t      exp_color;
    int                     read_errors;
    int                     busy_errors;
    int                     trace_errors;
    int                     cycles;
    int                     cycle_limit;
    string                  lines [$];

    tetris_color_grid dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .place      (place),
        .piece_type (piece_type),
        .rotation   (rotation),
        .location   (location),
        .clear      (clear),
        .full_rows  (full_rows),
        .busy       (busy),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

    grid_checker checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .place       (place),
        .busy        (busy),
        .check_en    (check_en),
        .read_addr   (read_addr),
        .exp_color   (exp_color),
        .read_data   (read_data),
        .read_errors (read_errors),
        .busy_errors (busy_errors)
    );

    bind grid_update_fsm tetris_color_grid_assertions fsm_checks_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .busy    (busy),
        .wr_en   (wr_en),
        .wr_addr (wr_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic load_trace();
        int    fd;
        string line;
        fd = $fopen("verif/grid_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file verif/grid_trace.txt");
            trace_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                // Comment lines and blank lines are dropped here
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // Returns on a falling edge with busy low
    task automatic wait_idle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic send_place(input int t, input int r, input int loc);
        wait_idle();
        place      = 1'b1;
        piece_type = piece_pkg::piece_type_t'(t[2:0]);
        rotation   = piece_pkg::rotation_t'(r[1:0]);
        location   = grid_pkg::cell_idx_t'(loc[7:0]);
        @(negedge clk);
        place = 1'b0;
    endtask

    task automatic send_clear(input int mask);
        wait_idle();
        clear     = 1'b1;
        full_rows = grid_pkg::row_mask_t'(mask[19:0]);
        @(negedge clk);
        clear = 1'b0;
    endtask

    // Follows a clear directly, so the DUT should still be busy
    task automatic place_while_busy(input int t, input int r, input int loc);
        if (busy) begin
            place      = 1'b1;
            piece_type = piece_pkg::piece_type_t'(t[2:0]);
            rotation   = piece_pkg::rotation_t'(r[1:0]);
            location   = grid_pkg::cell_idx_t'(loc[7:0]);
            @(negedge clk);
            place = 1'b0;
        end else begin
            $display("The DUT was idle where a place during a clear was expected");
            trace_errors++;
        end
    endtask

    task automatic check_read(input int addr, input int color);
        wait_idle();
        read_addr = grid_pkg::cell_idx_t'(addr[7:0]);
        exp_color = piece_pkg::color_t'(color[2:0]);
        check_en  = 1'b1;
        @(negedge clk);
        check_en = 1'b0;
    endtask

    task automatic bad_line(input string line);
        $display("Malformed trace line: %s", line);
        trace_errors++;
    endtask

    task automatic run_line(input string line);
        string args;
        int    a;
        int    b;
        int    c;
        int    n;
        args = line.substr(1, line.len() - 1);
        case (line[0])
            "P": begin
                n = $sscanf(args, "%d %d %d", a, b, c);
                if (n == 3) send_place(a, b, c);
                else bad_line(line);
            end
            "B": begin
                n = $sscanf(args, "%d %d %d", a, b, c);
                if (n == 3) place_while_busy(a, b, c);
                else bad_line(line);
            end
            "C": begin
                n = $sscanf(args, "%h", a);
                if (n == 1) send_clear(a);
                else bad_line(line);
            end
            "R": begin
                n = $sscanf(args, "%d %d", a, b);
                if (n == 2) check_read(a, b);
                else bad_line(line);
            end
            default: bad_line(line);
        endcase
    endtask

    initial begin
        int asserts;
        int total;
        rst_n        = 1'b0;
        place        = 1'b0;
        piece_type   = piece_pkg::PIECE_NONE;
        rotation     = '0;
        location     = '0;
        clear        = 1'b0;
        full_rows    = '0;
        read_addr    = '0;
        check_en     = 1'b0;
        exp_color    = '0;
        trace_errors = 0;
        load_trace();
        // Longest command is a clear of about 221 cycles
        cycle_limit = 300 * (lines.size() + 1);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        wait_idle();
        asserts = dut_i.execute_i.fsm_checks_i.fail_count;
        total   = read_errors + busy_errors + asserts + trace_errors;
        $display("Errors: %0d read, %0d busy, %0d assertion, %0d trace, over %0d trace lines",
                 read_errors, busy_errors, asserts, trace_errors, lines.size());
        if (total == 0 && lines.size() > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/grid_trace.txt
# P type rot loc = place, B type rot loc = place during a clear, C mask = clear (mask in hex)
# R addr color = read with expected color; all other fields are decimal
R 0 0
R 107 0
R 200 0
P 1 0 55
R 55 1
R 56 1
R 45 1
R 46 1
R 54 0
P 3 0 94
R 83 3
P 4 1 128
R 108 4
P 5 1 172
R 162 5
P 6 0 41
R 20 6
P 7 0 198
R 188 7
P 2 1 3
R 13 2
R 23 0
P 2 0 1
P 2 0 5
P 2 0 7
P 2 0 11
P 2 0 15
P 2 0 17
R 19 2
C 00003
B 1 0 185
R 0 6
R 2 0
R 35 1
R 152 5
R 168 7
R 188 0
R 185 0
R 176 0
C 00000
R 0 6
R 35 1
R 168 7

// File: compile.f
src/grid_pkg.sv
src/piece_pkg.sv
src/piece_cell_decoder.sv
src/grid_update_fsm.sv
src/color_grid_ram.sv
src/tetris_color_grid.sv
verif/tetris_color_grid_assertions.sv
verif/grid_checker.sv
verif/tb_tetris_color_grid.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator and run; the log must hold the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_tetris_color_grid -f compile.f -o sim_tetris \
    && ./obj_dir/sim_tetris +verilator+error+limit+1000 | tee sim.log \
    && grep -qxF '*** TEST PASSED ***' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
